//--- common/cv_input_params.svh
`ifndef CV_INPUT_PARAMS_SVH
`define CV_INPUT_PARAMS_SVH

// console controller ports
`define CV_NUM_PORTS 2

// board joystick word
`define CV_JOY_BITS 8

// keys 0-9, star, number, pt, bt, four directions, fire, arm
`define CV_KEYPAD_BITS 20

`define CV_SYNC_STAGES 2

`endif

//--- common/ps2_key_pkg.sv
`default_nettype none

package ps2_key_pkg;

	// event word from the I/O controller
	localparam int unsigned ps2_word_bits_c   = 11;
	localparam int unsigned ps2_toggle_bit_c  = 10;
	localparam int unsigned ps2_pressed_bit_c = 9;
	localparam int unsigned ps2_ext_bit_c     = 8;
	localparam int unsigned ps2_code_msb_c    = 7;
	localparam int unsigned ps2_code_lsb_c    = 0;

	localparam logic [7:0] ps2_sc_up_c     = 8'h75;
	localparam logic [7:0] ps2_sc_down_c   = 8'h72;
	localparam logic [7:0] ps2_sc_left_c   = 8'h6b;
	localparam logic [7:0] ps2_sc_right_c  = 8'h74;

	localparam logic [7:0] ps2_sc_0_c      = 8'h45; // number row
	localparam logic [7:0] ps2_sc_1_c      = 8'h16;
	localparam logic [7:0] ps2_sc_2_c      = 8'h1e;
	localparam logic [7:0] ps2_sc_3_c      = 8'h26;
	localparam logic [7:0] ps2_sc_4_c      = 8'h25;
	localparam logic [7:0] ps2_sc_5_c      = 8'h2e;
	localparam logic [7:0] ps2_sc_6_c      = 8'h36;
	localparam logic [7:0] ps2_sc_7_c      = 8'h3d;
	localparam logic [7:0] ps2_sc_8_c      = 8'h3e;
	localparam logic [7:0] ps2_sc_9_c      = 8'h46;

	// letter block laid out like the keypad
	localparam logic [7:0] ps2_sc_0_alt_c  = 8'h22; // x
	localparam logic [7:0] ps2_sc_4_alt_c  = 8'h15; // q
	localparam logic [7:0] ps2_sc_5_alt_c  = 8'h1d; // w
	localparam logic [7:0] ps2_sc_6_alt_c  = 8'h24; // e
	localparam logic [7:0] ps2_sc_7_alt_c  = 8'h1c; // a
	localparam logic [7:0] ps2_sc_8_alt_c  = 8'h1b; // s
	localparam logic [7:0] ps2_sc_9_alt_c  = 8'h23; // d
	localparam logic [7:0] ps2_sc_star_c   = 8'h1a; // z
	localparam logic [7:0] ps2_sc_number_c = 8'h21; // c

	localparam logic [7:0] ps2_sc_pt_l_c   = 8'h1f; // left gui
	localparam logic [7:0] ps2_sc_pt_r_c   = 8'h27; // right gui
	localparam logic [7:0] ps2_sc_bt_c     = 8'h11; // alt
	localparam logic [7:0] ps2_sc_fire_c   = 8'h14; // ctrl
	localparam logic [7:0] ps2_sc_arm_l_c  = 8'h12; // left shift
	localparam logic [7:0] ps2_sc_arm_r_c  = 8'h59; // right shift

endpackage

`default_nettype wire

//--- common/cv_ctrl_pkg.sv
`default_nettype none

`include "cv_input_params.svh"

package cv_ctrl_pkg;

	typedef logic [`CV_KEYPAD_BITS-1:0] keypad_vec_t;
	typedef logic [`CV_KEYPAD_BITS-1:0] key_state_t; // same layout as keypad_vec_t

	// keypad vector positions, keys 0-9 sit at their own index
	localparam int unsigned kp_key_0_c  = 0;
	localparam int unsigned kp_star_c   = 10;
	localparam int unsigned kp_number_c = 11;
	localparam int unsigned kp_pt_c     = 12;
	localparam int unsigned kp_bt_c     = 13;
	localparam int unsigned kp_up_c     = 14;
	localparam int unsigned kp_down_c   = 15;
	localparam int unsigned kp_left_c   = 16;
	localparam int unsigned kp_right_c  = 17;
	localparam int unsigned kp_fire_c   = 18;
	localparam int unsigned kp_arm_c    = 19;

	// board joystick bits
	localparam int unsigned joy_right_c  = 0;
	localparam int unsigned joy_left_c   = 1;
	localparam int unsigned joy_down_c   = 2;
	localparam int unsigned joy_up_c     = 3;
	localparam int unsigned joy_fire_c   = 4;
	localparam int unsigned joy_arm_c    = 5;
	localparam int unsigned joy_star_c   = 6;
	localparam int unsigned joy_number_c = 7;

	// codes the console reads on the data lines
	localparam logic [3:0] cv_key_0_c      = 4'b0011;
	localparam logic [3:0] cv_key_1_c      = 4'b1110;
	localparam logic [3:0] cv_key_2_c      = 4'b1101;
	localparam logic [3:0] cv_key_3_c      = 4'b0110;
	localparam logic [3:0] cv_key_4_c      = 4'b0001;
	localparam logic [3:0] cv_key_5_c      = 4'b1001;
	localparam logic [3:0] cv_key_6_c      = 4'b0111;
	localparam logic [3:0] cv_key_7_c      = 4'b1100;
	localparam logic [3:0] cv_key_8_c      = 4'b1000;
	localparam logic [3:0] cv_key_9_c      = 4'b1011;
	localparam logic [3:0] cv_key_star_c   = 4'b1010;
	localparam logic [3:0] cv_key_number_c = 4'b0101;
	localparam logic [3:0] cv_key_pt_c     = 4'b0100;
	localparam logic [3:0] cv_key_bt_c     = 4'b0010;
	localparam logic [3:0] cv_key_none_c   = 4'b1111;

endpackage

`default_nettype wire

//--- hdl/ps2_key_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_key_tracker
	import ps2_key_pkg::*;
	import cv_ctrl_pkg::*;
(
	input  wire                       clk_sys,
	input  wire                       arst_n_i,
	input  wire [ps2_word_bits_c-1:0] ps2_key_i,
	output key_state_t                key_state_o
);

	logic [ps2_word_bits_c-1:0] ps2_word_q;
	logic                       toggle_prev_q;
	key_state_t                 key_state_q;

	logic        new_event;
	logic        ps2_pressed;
	logic        ps2_ext;
	logic [7:0]  ps2_code;
	logic        key_hit;
	int unsigned key_idx;

	assign new_event   = ps2_word_q[ps2_toggle_bit_c] != toggle_prev_q;
	assign ps2_pressed = ps2_word_q[ps2_pressed_bit_c];
	assign ps2_ext     = ps2_word_q[ps2_ext_bit_c];
	assign ps2_code    = ps2_word_q[ps2_code_msb_c:ps2_code_lsb_c];

	always_comb begin
		key_hit = 1'b1;
		key_idx = kp_key_0_c;
		case (ps2_code)
			ps2_sc_0_c, ps2_sc_0_alt_c: key_idx = kp_key_0_c;
			ps2_sc_1_c:                 key_idx = kp_key_0_c + 1;
			ps2_sc_2_c:                 key_idx = kp_key_0_c + 2;
			ps2_sc_3_c:                 key_idx = kp_key_0_c + 3;
			ps2_sc_4_c, ps2_sc_4_alt_c: key_idx = kp_key_0_c + 4;
			ps2_sc_5_c, ps2_sc_5_alt_c: key_idx = kp_key_0_c + 5;
			ps2_sc_6_c, ps2_sc_6_alt_c: key_idx = kp_key_0_c + 6;
			ps2_sc_7_c, ps2_sc_7_alt_c: key_idx = kp_key_0_c + 7;
			ps2_sc_8_c, ps2_sc_8_alt_c: key_idx = kp_key_0_c + 8;
			ps2_sc_9_c, ps2_sc_9_alt_c: key_idx = kp_key_0_c + 9;
			ps2_sc_star_c:              key_idx = kp_star_c;
			ps2_sc_number_c:            key_idx = kp_number_c;
			ps2_sc_pt_l_c, ps2_sc_pt_r_c: key_idx = kp_pt_c;
			ps2_sc_bt_c:                key_idx = kp_bt_c;
			ps2_sc_up_c:                key_idx = kp_up_c;
			ps2_sc_down_c:              key_idx = kp_down_c;
			ps2_sc_left_c:              key_idx = kp_left_c;
			ps2_sc_right_c:             key_idx = kp_right_c;
			ps2_sc_fire_c:              key_idx = kp_fire_c;
			ps2_sc_arm_l_c, ps2_sc_arm_r_c: begin
				key_idx = kp_arm_c;
				key_hit = ~ps2_ext; // E0 12 is a fake shift from the cursor block
			end
			default: key_hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ps2_word_q    <= '0;
			toggle_prev_q <= 1'b0;
			key_state_q   <= '0;
		end else begin
			ps2_word_q    <= ps2_key_i;
			toggle_prev_q <= ps2_word_q[ps2_toggle_bit_c];
			if (new_event && key_hit) begin
				key_state_q[key_idx] <= ps2_pressed; // make sets, break clears
			end
		end
	end

	assign key_state_o = key_state_q;

endmodule

`default_nettype wire

//--- hdl/joystick_sync.sv
`timescale 1ns/1ps
`default_nettype none

`include "cv_input_params.svh"

module joystick_sync (
	input  wire                    clk_sys,
	input  wire                    arst_n_i,
	input  wire [`CV_JOY_BITS-1:0] joy_a_i,
	input  wire [`CV_JOY_BITS-1:0] joy_b_i,
	input  wire                    swap_joy_i,
	output logic [`CV_JOY_BITS-1:0] joy_main_o,
	output logic [`CV_JOY_BITS-1:0] joy_aux_o
);

	logic [`CV_SYNC_STAGES-1:0][`CV_JOY_BITS-1:0] joy_a_q;
	logic [`CV_SYNC_STAGES-1:0][`CV_JOY_BITS-1:0] joy_b_q;
	logic [`CV_SYNC_STAGES-1:0]                   swap_q; // kept aligned with the data

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			joy_a_q <= '0;
			joy_b_q <= '0;
			swap_q  <= '0;
		end else begin
			joy_a_q <= {joy_a_q[`CV_SYNC_STAGES-2:0], joy_a_i};
			joy_b_q <= {joy_b_q[`CV_SYNC_STAGES-2:0], joy_b_i};
			swap_q  <= {swap_q[`CV_SYNC_STAGES-2:0], swap_joy_i};
		end
	end

	always_comb begin
		joy_main_o = joy_a_q[`CV_SYNC_STAGES-1];
		joy_aux_o  = joy_b_q[`CV_SYNC_STAGES-1];
		if (swap_q[`CV_SYNC_STAGES-1]) begin
			joy_main_o = joy_b_q[`CV_SYNC_STAGES-1];
			joy_aux_o  = joy_a_q[`CV_SYNC_STAGES-1];
		end
	end

endmodule

`default_nettype wire

//--- hdl/cv_keypad_encoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "cv_input_params.svh"

module cv_keypad_encoder
	import cv_ctrl_pkg::*;
(
	input  wire  key_state_t             key_state_i,
	input  wire  [`CV_JOY_BITS-1:0]      joy_main_i,
	input  wire  [`CV_JOY_BITS-1:0]      joy_aux_i,
	input  wire  [`CV_NUM_PORTS-1:0]     keypad_strobe_n_i,
	input  wire  [`CV_NUM_PORTS-1:0]     joy_strobe_n_i,
	output logic [4*`CV_NUM_PORTS-1:0]   ctrl_data_n_o,
	output logic [`CV_NUM_PORTS-1:0]     ctrl_fire_n_o
);

	// place a board joystick word at its keypad vector positions
	function automatic keypad_vec_t joy_to_vec(input logic [`CV_JOY_BITS-1:0] joy);
		keypad_vec_t v;
		v = '0;
		v[kp_right_c]  = joy[joy_right_c];
		v[kp_left_c]   = joy[joy_left_c];
		v[kp_down_c]   = joy[joy_down_c];
		v[kp_up_c]     = joy[joy_up_c];
		v[kp_fire_c]   = joy[joy_fire_c];
		v[kp_arm_c]    = joy[joy_arm_c];
		v[kp_star_c]   = joy[joy_star_c];
		v[kp_number_c] = joy[joy_number_c];
		return v;
	endfunction

	// lowest set index wins
	function automatic logic [3:0] keypad_code(input keypad_vec_t v);
		logic [3:0] code;
		if      (v[kp_key_0_c])     code = cv_key_0_c;
		else if (v[kp_key_0_c + 1]) code = cv_key_1_c;
		else if (v[kp_key_0_c + 2]) code = cv_key_2_c;
		else if (v[kp_key_0_c + 3]) code = cv_key_3_c;
		else if (v[kp_key_0_c + 4]) code = cv_key_4_c;
		else if (v[kp_key_0_c + 5]) code = cv_key_5_c;
		else if (v[kp_key_0_c + 6]) code = cv_key_6_c;
		else if (v[kp_key_0_c + 7]) code = cv_key_7_c;
		else if (v[kp_key_0_c + 8]) code = cv_key_8_c;
		else if (v[kp_key_0_c + 9]) code = cv_key_9_c;
		else if (v[kp_star_c])      code = cv_key_star_c;
		else if (v[kp_number_c])    code = cv_key_number_c;
		else if (v[kp_pt_c])        code = cv_key_pt_c;
		else if (v[kp_bt_c])        code = cv_key_bt_c;
		else                        code = cv_key_none_c;
		return code;
	endfunction

	keypad_vec_t kp_vec [`CV_NUM_PORTS];

	assign kp_vec[0] = key_state_i | joy_to_vec(joy_main_i); // keyboard shares port 0
	assign kp_vec[1] = joy_to_vec(joy_aux_i);

	for (genvar p = 0; p < `CV_NUM_PORTS; p++) begin : g_port
		logic [3:0] kp_nib;
		logic [3:0] joy_nib;
		logic       kp_fire_n;
		logic       joy_fire_n;

		always_comb begin
			kp_nib     = 4'b1111;
			kp_fire_n  = 1'b1;
			joy_nib    = 4'b1111;
			joy_fire_n = 1'b1;
			if (!keypad_strobe_n_i[p]) begin
				kp_nib    = keypad_code(kp_vec[p]);
				kp_fire_n = ~kp_vec[p][kp_arm_c];
			end
			if (!joy_strobe_n_i[p]) begin
				joy_nib    = ~{kp_vec[p][kp_right_c], kp_vec[p][kp_left_c],
					kp_vec[p][kp_down_c], kp_vec[p][kp_up_c]};
				joy_fire_n = ~kp_vec[p][kp_fire_c];
			end
		end

		assign ctrl_data_n_o[4*p +: 4] = kp_nib & joy_nib;
		assign ctrl_fire_n_o[p]        = kp_fire_n & joy_fire_n;
	end

endmodule

`default_nettype wire

//--- hdl/cv_controller_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cv_input_params.svh"

module cv_controller_top
	import cv_ctrl_pkg::*;
(
	input  wire                        clk_sys,
	input  wire                        arst_n_i,
	input  wire  [10:0]                ps2_key_i,
	input  wire  [`CV_JOY_BITS-1:0]    joy_a_i,
	input  wire  [`CV_JOY_BITS-1:0]    joy_b_i,
	input  wire                        swap_joy_i,
	input  wire  [`CV_NUM_PORTS-1:0]   keypad_strobe_n_i,
	input  wire  [`CV_NUM_PORTS-1:0]   joy_strobe_n_i,
	output logic [4*`CV_NUM_PORTS-1:0] ctrl_data_n_o,
	output logic [`CV_NUM_PORTS-1:0]   ctrl_fire_n_o
);

	key_state_t              key_state;
	logic [`CV_JOY_BITS-1:0] joy_main; // feeds port 0 with the keyboard
	logic [`CV_JOY_BITS-1:0] joy_aux;

	ps2_key_tracker ps2_key_tracker_inst (
		.clk_sys     (clk_sys),
		.arst_n_i    (arst_n_i),
		.ps2_key_i   (ps2_key_i),
		.key_state_o (key_state)
	);

	joystick_sync joystick_sync_inst (
		.clk_sys    (clk_sys),
		.arst_n_i   (arst_n_i),
		.joy_a_i    (joy_a_i),
		.joy_b_i    (joy_b_i),
		.swap_joy_i (swap_joy_i),
		.joy_main_o (joy_main),
		.joy_aux_o  (joy_aux)
	);

	cv_keypad_encoder cv_keypad_encoder_inst (
		.key_state_i       (key_state),
		.joy_main_i        (joy_main),
		.joy_aux_i         (joy_aux),
		.keypad_strobe_n_i (keypad_strobe_n_i),
		.joy_strobe_n_i    (joy_strobe_n_i),
		.ctrl_data_n_o     (ctrl_data_n_o),
		.ctrl_fire_n_o     (ctrl_fire_n_o)
	);

endmodule

`default_nettype wire

//--- testbench/cv_controller_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "cv_input_params.svh"

module cv_controller_properties (
	input wire                       clk_sys,
	input wire                       arst_n_i,
	input wire [`CV_NUM_PORTS-1:0]   keypad_strobe_n_i,
	input wire [`CV_NUM_PORTS-1:0]   joy_strobe_n_i,
	input wire [4*`CV_NUM_PORTS-1:0] ctrl_data_n_o,
	input wire [`CV_NUM_PORTS-1:0]   ctrl_fire_n_o
);

	int unsigned failed_checks = 0; // read by the testbench at the end

	for (genvar p = 0; p < `CV_NUM_PORTS; p++) begin : g_port
		idle_port_high: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
			(keypad_strobe_n_i[p] && joy_strobe_n_i[p]) |->
			(ctrl_data_n_o[4*p +: 4] == 4'hf && ctrl_fire_n_o[p]))
		else begin
			$error("port %0d not idle while both strobes are high", p);
			failed_checks++;
		end

		fire_needs_strobe: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
			!ctrl_fire_n_o[p] |-> (!keypad_strobe_n_i[p] || !joy_strobe_n_i[p]))
		else begin
			$error("port %0d fire low with no strobe active", p);
			failed_checks++;
		end
	end

	reset_outputs_high: assert property (@(posedge clk_sys)
		!arst_n_i |-> (&ctrl_data_n_o && &ctrl_fire_n_o))
	else begin
		$error("controller lines not all high during reset");
		failed_checks++;
	end

endmodule

bind cv_controller_top cv_controller_properties cv_controller_properties_inst (
	.clk_sys           (clk_sys),
	.arst_n_i          (arst_n_i),
	.keypad_strobe_n_i (keypad_strobe_n_i),
	.joy_strobe_n_i    (joy_strobe_n_i),
	.ctrl_data_n_o     (ctrl_data_n_o),
	.ctrl_fire_n_o     (ctrl_fire_n_o)
);

`default_nettype wire

//--- testbench/tb_cv_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "cv_input_params.svh"

module tb_cv_controller;

	localparam time         clk_period_c   = 100ns;
	localparam time         drive_delay_c  = 5ns;
	localparam int unsigned reset_cycles_c = 16;
	localparam int unsigned step_edges_c   = 4;
	localparam string       vector_file_c  = "testbench/cv_controller_vectors.txt";

	logic                         clk_sys;
	logic                         arst_n;
	logic [10:0]                  ps2_key;
	logic [`CV_JOY_BITS-1:0]      joy_a;
	logic [`CV_JOY_BITS-1:0]      joy_b;
	logic                         swap_joy;
	logic [`CV_NUM_PORTS-1:0]     keypad_strobe_n;
	logic [`CV_NUM_PORTS-1:0]     joy_strobe_n;
	logic [4*`CV_NUM_PORTS-1:0]   ctrl_data_n;
	logic [`CV_NUM_PORTS-1:0]     ctrl_fire_n;

	// one entry per vector line
	string                    vec_name [$];
	logic [10:0]              vec_ps2 [$];
	logic [`CV_JOY_BITS-1:0]  vec_joy_a [$];
	logic [`CV_JOY_BITS-1:0]  vec_joy_b [$];
	logic                     vec_swap [$];
	logic [1:0]               vec_kp_strobe [$];
	logic [1:0]               vec_joy_strobe [$];
	logic [7:0]               vec_data [$];
	logic [1:0]               vec_fire [$];
	bit                       vectors_loaded = 1'b0;

	cv_controller_top cv_controller_top_inst (
		.clk_sys           (clk_sys),
		.arst_n_i          (arst_n),
		.ps2_key_i         (ps2_key),
		.joy_a_i           (joy_a),
		.joy_b_i           (joy_b),
		.swap_joy_i        (swap_joy),
		.keypad_strobe_n_i (keypad_strobe_n),
		.joy_strobe_n_i    (joy_strobe_n),
		.ctrl_data_n_o     (ctrl_data_n),
		.ctrl_fire_n_o     (ctrl_fire_n)
	);

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1, "run stopped");
	endtask

	task automatic compare_value(input string test_name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected) begin
			$display("mismatch in %s: expected %h, actual %h", test_name, expected, actual);
			stop_with_failure("output check did not match the vector");
		end
	endtask

	task automatic load_vectors();
		int          fd;
		int          n;
		string       line;
		string       name;
		logic [10:0] ps2;
		logic [7:0]  ja;
		logic [7:0]  jb;
		logic        sw;
		logic [1:0]  kp;
		logic [1:0]  js;
		logic [7:0]  data;
		logic [1:0]  fire;
		fd = $fopen(vector_file_c, "r");
		if (fd == 0) begin
			stop_with_failure({"cannot open the vector file ", vector_file_c});
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
				continue; // blank line or column notes
			end
			n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", name, ps2, ja, jb, sw, kp, js,
				data, fire);
			if (n != 9) begin
				stop_with_failure({"unreadable line in the vector file: ", line});
			end
			vec_name.push_back(name);
			vec_ps2.push_back(ps2);
			vec_joy_a.push_back(ja);
			vec_joy_b.push_back(jb);
			vec_swap.push_back(sw);
			vec_kp_strobe.push_back(kp);
			vec_joy_strobe.push_back(js);
			vec_data.push_back(data);
			vec_fire.push_back(fire);
		end
		$fclose(fd);
	endtask

	task automatic run_step(input int i);
		@(posedge clk_sys);
		#drive_delay_c;
		ps2_key         = vec_ps2[i];
		joy_a           = vec_joy_a[i];
		joy_b           = vec_joy_b[i];
		swap_joy        = vec_swap[i];
		keypad_strobe_n = vec_kp_strobe[i];
		joy_strobe_n    = vec_joy_strobe[i];
		repeat (step_edges_c) @(posedge clk_sys); // covers the 2 cycle input path
		#drive_delay_c;
		compare_value({vec_name[i], " data"}, vec_data[i], ctrl_data_n);
		compare_value({vec_name[i], " fire"}, {6'b0, vec_fire[i]}, {6'b0, ctrl_fire_n});
	endtask

	initial begin : clock_gen
		clk_sys = 1'b0;
		forever #(clk_period_c / 2) clk_sys = ~clk_sys;
	end

	initial begin : watchdog
		wait (vectors_loaded);
		repeat (reset_cycles_c + 6 * vec_name.size()) @(posedge clk_sys);
		stop_with_failure("timeout, the vector steps did not finish in time");
	end

	initial begin : assertion_monitor
		wait (cv_controller_top_inst.cv_controller_properties_inst.failed_checks != 0);
		stop_with_failure("a bound assertion failed");
	end

	initial begin : stimulus
		arst_n          = 1'b0;
		ps2_key         = '0;
		joy_a           = '1; // must stay out of the reset flops
		joy_b           = '1;
		swap_joy        = 1'b0;
		keypad_strobe_n = '0; // reset state visible on the lines
		joy_strobe_n    = '0;
		load_vectors();
		if (vec_name.size() == 0) begin
			stop_with_failure("the vector file holds no vectors");
		end
		vectors_loaded = 1'b1;
		repeat (reset_cycles_c) @(posedge clk_sys);
		#drive_delay_c;
		arst_n = 1'b1;
		for (int i = 0; i < vec_name.size(); i++) begin
			run_step(i);
		end
		if (cv_controller_top_inst.cv_controller_properties_inst.failed_checks != 0) begin
			stop_with_failure("one or more bound assertions failed");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- testbench/cv_controller_vectors.txt
# name ps2_key joy_a joy_b swap kp_strobe_n joy_strobe_n exp_data_n exp_fire_n
# all values hex, strobe and fire bit 0 is port 0, data low nibble is port 0
reset_idle        000 00 00 0 3 3 ff 3
keypad_none       000 00 00 0 0 3 ff 3
key5_make         62e 00 00 0 0 3 f9 3
key2_make         21e 00 00 0 0 3 fd 3
key2_same_toggle  01e 00 00 0 0 3 fd 3
key2_break        41e 00 00 0 0 3 f9 3
key5_break        02e 00 00 0 0 3 ff 3
joy_up_fire       02e 18 00 0 3 0 fe 2
joy_swap          02e 18 00 1 3 0 ef 1
joy_release       02e 00 00 0 3 0 ff 3
merge_left_right  66b 01 00 0 3 0 f3 3
merge_release     06b 00 00 0 3 0 ff 3
joy_star_keypad   06b 40 00 0 0 3 fa 3
both_strobes_p0   06b 68 00 0 0 0 fa 2
both_strobes_p1   06b 00 91 0 1 1 5f 1
alt_q_make        615 00 00 0 0 3 f1 3
alt_q_break       015 00 00 0 0 3 ff 3
ext_shift_ignored 712 00 00 0 0 3 ff 3
arm_make          212 00 00 0 0 3 ff 2
arm_break         412 00 00 0 0 3 ff 3
final_idle        412 00 00 0 3 3 ff 3

//--- verilog.f
+incdir+common
common/ps2_key_pkg.sv
common/cv_ctrl_pkg.sv
hdl/ps2_key_tracker.sv
hdl/joystick_sync.sv
hdl/cv_keypad_encoder.sv
hdl/cv_controller_top.sv
testbench/cv_controller_properties.sv
testbench/tb_cv_controller.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the controller testbench with Verilator from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f --top-module tb_cv_controller

# keep going on a non-zero exit so the output can be searched
sim_out=$(./obj_dir/Vtb_cv_controller 2>&1 || true)
echo "$sim_out"

if echo "$sim_out" | grep -q "Test completed successfully"; then
	exit 0
else
	echo "simulation did not pass"
	exit 1
fi
